// ==== common/iso14443a_defines.svh ====
// register map, transmit fifo depth, bit timing and crc_a seed
`ifndef ISO14443A_DEFINES_SVH
`define ISO14443A_DEFINES_SVH

// apb register offsets
`define REG_CTRL    8'h00
`define REG_TXDATA  8'h04
`define REG_FDT     8'h08
`define REG_STATUS  8'h0C
`define REG_CRC     8'h10

`define TX_FIFO_DEPTH 16

// clocks per bit, each half-bit is half of this
`define BIT_TICKS 16

`define CRC_A_INIT 16'h6363

`endif

// ==== common/iso14443a_pkg.sv ====
// shared types for the iso 14443-a picc transmit path
// frame config, bit handshake, fsm states and apb request/response
package iso14443a_pkg;

    // frame setup captured on the start command
    typedef struct packed {
        // bits in the first byte, 0 means a full byte
        logic [2:0] first_bits;
        logic       append_crc;
    } tx_cfg_t;

    // one bit of the valid/req bit handshake
    typedef struct packed {
        logic data;
        logic valid;
    } bit_stream_t;

    typedef enum logic [2:0] {
        enc_idle,
        enc_data,
        enc_parity,
        enc_crc,
        enc_crc_parity,
        enc_end
    } enc_state_e;

    typedef enum logic [1:0] {
        man_idle,
        man_soc,
        man_bit,
        man_eoc
    } man_state_e;

    typedef struct packed {
        logic [7:0]  paddr;
        logic [31:0] pwdata;
        logic        pwrite;
        logic        psel;
        logic        penable;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== verilog/apb_tx_regs.sv ====
// apb slave with ctrl, fdt, status and crc registers
// plus the circular transmit byte fifo
`timescale 1ns/10ps
`include "iso14443a_defines.svh"

module apb_tx_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  iso14443a_pkg::apb_req_t apb_req,
    output iso14443a_pkg::apb_rsp_t apb_rsp,
    output logic                    start,
    output iso14443a_pkg::tx_cfg_t  cfg,
    output logic [15:0]             fdt,
    input  logic                    fifo_pop,
    output logic [7:0]              fifo_byte,
    output logic                    fifo_empty,
    input  logic [15:0]             crc,
    input  logic                    tx_done
);
    localparam int ptr_w = $clog2(`TX_FIFO_DEPTH);

    logic [7:0]     mem [`TX_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0] level;
    logic           fifo_full;
    logic           busy;
    logic           done;
    logic           access;
    logic           err;
    logic           wr_en;
    logic           push;
    logic           start_cmd;
    logic [31:0]    rdata;

    assign fifo_full  = level == (ptr_w + 1)'(`TX_FIFO_DEPTH);
    assign fifo_empty = level == '0;
    // head byte is always visible to the serializer
    assign fifo_byte  = mem[rd_ptr];

    // access phase of a transfer
    assign access = apb_req.psel && apb_req.penable;

    // read mux and error decode
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb_req.paddr)
            `REG_CTRL: begin
                rdata = {27'd0, cfg.append_crc, cfg.first_bits, 1'b0};
                // restart refused while a frame is in flight
                err   = apb_req.pwrite && apb_req.pwdata[0] && busy;
            end
            `REG_TXDATA: err = apb_req.pwrite && fifo_full;
            `REG_FDT:    rdata = {16'd0, fdt};
            `REG_STATUS: rdata = (32'(level) << 8) | {30'd0, done, busy};
            `REG_CRC:    rdata = {16'd0, crc};
            default:     err = 1'b1;
        endcase
    end

    // zero wait state slave
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && err;

    assign wr_en     = access && apb_req.pwrite && !err;
    assign push      = wr_en && apb_req.paddr == `REG_TXDATA;
    assign start_cmd = wr_en && apb_req.paddr == `REG_CTRL && apb_req.pwdata[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start  <= 1'b0;
            cfg    <= '0;
            fdt    <= '0;
            busy   <= 1'b0;
            done   <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            start <= start_cmd;
            if (start_cmd) begin
                cfg.first_bits <= apb_req.pwdata[3:1];
                cfg.append_crc <= apb_req.pwdata[4];
                busy           <= 1'b1;
                done           <= 1'b0;
            end else if (tx_done) begin
                busy <= 1'b0;
                // sticky until the next start
                done <= 1'b1;
            end
            if (wr_en && apb_req.paddr == `REG_FDT) begin
                fdt <= apb_req.pwdata[15:0];
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop && !fifo_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // level moves only when one side acts alone
            if (push && !(fifo_pop && !fifo_empty)) begin
                level <= level + 1'b1;
            end else if (!push && fifo_pop && !fifo_empty) begin
                level <= level - 1'b1;
            end
        end
    end

    // fifo storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= apb_req.pwdata[7:0];
        end
    end

endmodule

// ==== verilog/fdt_timer.sv ====
// frame delay timer, one cycle trigger fdt+1 clocks after start
`timescale 1ns/10ps

module fdt_timer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [15:0] fdt,
    output logic        trigger
);
    logic [15:0] count;
    logic        running;

    // fires on the cycle the count reaches zero
    assign trigger = running && count == 16'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            // a new start always reloads
            count   <= fdt;
            running <= 1'b1;
        end else if (running) begin
            if (count == 16'd0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/tx_byte_serializer.sv ====
// byte to bit serializer, lsb first, with crc_a over the popped bytes
`timescale 1ns/10ps
`include "iso14443a_defines.svh"

module tx_byte_serializer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  iso14443a_pkg::tx_cfg_t     cfg,
    output logic                       fifo_pop,
    input  logic [7:0]                 fifo_byte,
    input  logic                       fifo_empty,
    output iso14443a_pkg::bit_stream_t bits,
    input  logic                       in_req,
    output logic [15:0]                crc
);
    logic [7:0] shreg;
    logic [3:0] bits_left;
    logic       valid;
    logic       byte_end;
    logic       load_byte;
    logic       shift_bit;

    // crc_a one byte at a time, reflected 0x8408 polynomial
    function automatic logic [15:0] crc_a_byte(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        r = c ^ {8'd0, b};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
        end
        return r;
    endfunction

    assign byte_end  = in_req && valid && bits_left == 4'd1;
    assign load_byte = (start || byte_end) && !fifo_empty;
    assign shift_bit = in_req && valid && bits_left > 4'd1;

    assign bits.data  = shreg[0];
    assign bits.valid = valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            fifo_pop  <= 1'b0;
            bits_left <= '0;
            crc       <= `CRC_A_INIT;
        end else begin
            fifo_pop <= load_byte;
            if (start) begin
                valid     <= !fifo_empty;
                // first byte may be short, 0 stands for 8
                bits_left <= {cfg.first_bits == 3'd0, cfg.first_bits};
                crc       <= fifo_empty ? `CRC_A_INIT : crc_a_byte(`CRC_A_INIT, fifo_byte);
            end else if (byte_end) begin
                // nothing left means end of data
                valid     <= !fifo_empty;
                bits_left <= 4'd8;
                if (!fifo_empty) begin
                    crc <= crc_a_byte(crc, fifo_byte);
                end
            end else if (shift_bit) begin
                bits_left <= bits_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_byte) begin
            shreg <= fifo_byte;
        end else if (shift_bit) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

// ==== frame_encode/frame_encode.sv ====
// frame encoder, adds odd parity and the crc_a bytes to the bit stream
// sending is released by the frame delay trigger
`timescale 1ns/10ps

module frame_encode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fdt_trigger,
    input  iso14443a_pkg::bit_stream_t in,
    output logic                       in_req,
    input  iso14443a_pkg::tx_cfg_t     cfg,
    input  logic [15:0]                crc,
    output iso14443a_pkg::bit_stream_t out,
    input  logic                       out_req
);
    iso14443a_pkg::enc_state_e state;

    // bits still to go before the next parity bit, 0 means 8
    logic [2:0]  bits_remaining;
    logic        parity;
    logic [15:0] cached_crc;
    // high while the second crc byte is going out
    logic        crc_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= iso14443a_pkg::enc_idle;
            in_req    <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            // single cycle request
            in_req <= 1'b0;

            case (state)
                iso14443a_pkg::enc_idle: begin
                    // nothing happens without data on the trigger
                    if (fdt_trigger && in.valid) begin
                        out.data       <= in.data;
                        out.valid      <= 1'b1;
                        parity         <= !in.data;
                        bits_remaining <= cfg.first_bits - 1'b1;
                        in_req         <= 1'b1;
                        if (cfg.first_bits == 3'd1) begin
                            state <= iso14443a_pkg::enc_parity;
                        end else begin
                            state <= iso14443a_pkg::enc_data;
                        end
                    end
                end

                iso14443a_pkg::enc_data: begin
                    // in.valid not checked, every byte ends on a parity bit
                    if (out_req) begin
                        out.data       <= in.data;
                        parity         <= parity ^ in.data;
                        in_req         <= 1'b1;
                        bits_remaining <= bits_remaining - 1'b1;
                        if (bits_remaining == 3'd1) begin
                            state <= iso14443a_pkg::enc_parity;
                        end
                    end
                end

                iso14443a_pkg::enc_parity: begin
                    if (out_req) begin
                        out.data <= parity;
                        if (in.valid) begin
                            // another full byte
                            bits_remaining <= 3'd0;
                            parity         <= 1'b1;
                            state          <= iso14443a_pkg::enc_data;
                        end else if (cfg.append_crc) begin
                            // crc goes out low byte first
                            cached_crc     <= crc;
                            crc_byte       <= 1'b0;
                            bits_remaining <= 3'd0;
                            parity         <= 1'b1;
                            state          <= iso14443a_pkg::enc_crc;
                        end else begin
                            state <= iso14443a_pkg::enc_end;
                        end
                    end
                end

                iso14443a_pkg::enc_crc: begin
                    if (out_req) begin
                        out.data         <= cached_crc[0];
                        cached_crc[14:0] <= cached_crc[15:1];
                        parity           <= parity ^ cached_crc[0];
                        bits_remaining   <= bits_remaining - 1'b1;
                        if (bits_remaining == 3'd1) begin
                            state <= iso14443a_pkg::enc_crc_parity;
                        end
                    end
                end

                iso14443a_pkg::enc_crc_parity: begin
                    if (out_req) begin
                        out.data <= parity;
                        if (!crc_byte) begin
                            crc_byte       <= 1'b1;
                            bits_remaining <= 3'd0;
                            parity         <= 1'b1;
                            state          <= iso14443a_pkg::enc_crc;
                        end else begin
                            state <= iso14443a_pkg::enc_end;
                        end
                    end
                end

                iso14443a_pkg::enc_end: begin
                    // final parity bit consumed, close the frame
                    if (out_req) begin
                        out.valid <= 1'b0;
                        state     <= iso14443a_pkg::enc_idle;
                    end
                end

                default: state <= iso14443a_pkg::enc_idle;
            endcase
        end
    end

endmodule

// ==== verilog/manchester_encoder.sv ====
// manchester bit encoder, start bit, data bits, then one idle bit period
`timescale 1ns/10ps
`include "iso14443a_defines.svh"

module manchester_encoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  iso14443a_pkg::bit_stream_t in,
    output logic                       out_req,
    output logic                       tx_mod,
    output logic                       tx_active,
    output logic                       tx_done
);
    localparam int tick_w = $clog2(`BIT_TICKS);
    localparam logic [tick_w-1:0] last_tick = tick_w'(`BIT_TICKS - 1);
    localparam logic [tick_w-1:0] half_tick = tick_w'(`BIT_TICKS / 2);

    iso14443a_pkg::man_state_e state;
    logic [tick_w-1:0] tick;
    logic              first_half;
    logic              bit_end;

    assign first_half = tick < half_tick;
    assign bit_end    = tick == last_tick;

    // a 1 modulates the first half, a 0 the second
    always_comb begin
        case (state)
            iso14443a_pkg::man_soc: tx_mod = first_half;
            iso14443a_pkg::man_bit: tx_mod = in.valid && (in.data == first_half);
            default:                tx_mod = 1'b0;
        endcase
    end

    // next bit wanted at the end of each data bit
    assign out_req   = state == iso14443a_pkg::man_bit && bit_end && in.valid;
    assign tx_active = state != iso14443a_pkg::man_idle;
    assign tx_done   = state == iso14443a_pkg::man_eoc && bit_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= iso14443a_pkg::man_idle;
            tick  <= '0;
        end else begin
            tick <= (state == iso14443a_pkg::man_idle || bit_end) ? '0 : tick + 1'b1;
            case (state)
                iso14443a_pkg::man_idle:
                    if (in.valid) state <= iso14443a_pkg::man_soc;
                iso14443a_pkg::man_soc:
                    if (bit_end) state <= iso14443a_pkg::man_bit;
                // valid drops just after the last request
                iso14443a_pkg::man_bit:
                    if (!in.valid) state <= iso14443a_pkg::man_eoc;
                iso14443a_pkg::man_eoc:
                    if (bit_end) state <= iso14443a_pkg::man_idle;
                default: state <= iso14443a_pkg::man_idle;
            endcase
        end
    end

endmodule

// ==== verilog/iso14443a_tx.sv ====
// transmit path top, apb registers through to the manchester output
`timescale 1ns/10ps

module iso14443a_tx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  iso14443a_pkg::apb_req_t apb_req,
    output iso14443a_pkg::apb_rsp_t apb_rsp,
    output logic                    tx_mod,
    output logic                    tx_active,
    output logic                    tx_done
);
    logic                       start;
    iso14443a_pkg::tx_cfg_t     cfg;
    logic [15:0]                fdt;
    logic                       fifo_pop;
    logic [7:0]                 fifo_byte;
    logic                       fifo_empty;
    logic [15:0]                crc;
    logic                       trigger;
    // serializer to frame encoder
    iso14443a_pkg::bit_stream_t ser_bits;
    logic                       ser_req;
    // frame encoder to manchester encoder
    iso14443a_pkg::bit_stream_t enc_bits;
    logic                       enc_req;

    apb_tx_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .start      (start),
        .cfg        (cfg),
        .fdt        (fdt),
        .fifo_pop   (fifo_pop),
        .fifo_byte  (fifo_byte),
        .fifo_empty (fifo_empty),
        .crc        (crc),
        .tx_done    (tx_done)
    );

    fdt_timer u_fdt (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .fdt     (fdt),
        .trigger (trigger)
    );

    tx_byte_serializer u_ser (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .fifo_pop   (fifo_pop),
        .fifo_byte  (fifo_byte),
        .fifo_empty (fifo_empty),
        .bits       (ser_bits),
        .in_req     (ser_req),
        .crc        (crc)
    );

    frame_encode u_enc (
        .clk         (clk),
        .rst_n       (rst_n),
        .fdt_trigger (trigger),
        .in          (ser_bits),
        .in_req      (ser_req),
        .cfg         (cfg),
        .crc         (crc),
        .out         (enc_bits),
        .out_req     (enc_req)
    );

    manchester_encoder u_man (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (enc_bits),
        .out_req   (enc_req),
        .tx_mod    (tx_mod),
        .tx_active (tx_active),
        .tx_done   (tx_done)
    );

endmodule

// ==== tests/tb_iso14443a_tx.sv ====
// testbench for the iso 14443-a transmit path
// programs frames over apb, decodes the manchester output and checks bits and registers
`timescale 1ns/10ps
`include "iso14443a_defines.svh"

module tb_iso14443a_tx;
    // cycles from the start write to tx_active beyond the programmed frame delay
    localparam int setup_cycles = 4;

    logic                    clk;
    logic                    rst_n;
    iso14443a_pkg::apb_req_t apb_req;
    iso14443a_pkg::apb_rsp_t apb_rsp;
    logic                    tx_mod;
    logic                    tx_active;
    logic                    tx_done;

    // one entry per line of the case file
    string       case_name[$];
    int          case_fb[$];
    int          case_crcf[$];
    int          case_fdt[$];
    int          case_nb[$];
    int          case_base[$];
    logic [7:0]  case_bytes[$];
    logic [15:0] case_crc[$];

    logic  exp_bits[$];
    logic  rx_bits[$];
    logic  decode_done;
    logic  bad_symbol;
    logic  in_frame;
    logic  half_a;
    logic  half_b;
    string test_name;
    int    errors;
    int    case_errors;
    int    cycles;
    int    cycle_limit;

    iso14443a_tx dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .tx_mod    (tx_mod),
        .tx_active (tx_active),
        .tx_done   (tx_done)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // run limit worked out from the case file
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // manchester decoder sampling the middle of each half-bit
    always begin
        @(posedge tx_active);
        rx_bits.delete();
        decode_done = 1'b0;
        bad_symbol  = 1'b0;
        in_frame    = 1'b1;
        // tx_active rises on tick 0 of the start bit so the first sample lands on tick 4
        repeat (`BIT_TICKS / 4 + 1) @(negedge clk);
        while (in_frame) begin
            half_a = tx_mod;
            repeat (`BIT_TICKS / 2) @(negedge clk);
            half_b = tx_mod;
            if (half_a != half_b) begin
                // modulated first half is a 1
                rx_bits.push_back(half_a);
                repeat (`BIT_TICKS / 2) @(negedge clk);
            end else begin
                // equal halves end the frame and only quiet ones are a clean end
                bad_symbol = half_a;
                in_frame   = 1'b0;
            end
        end
        decode_done = 1'b1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", test_name, what,
                     expected, actual);
            errors++;
            case_errors++;
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(0, 2)) @(posedge clk);
    endtask

    // one apb transfer with setup then access and the response sampled mid access phase
    task automatic bus_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        apb_req.pwrite  <= write;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // zero wait state slave
        check_value("pready", 1, 32'(apb_rsp.pready));
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
    endtask

    // lsb first data bits followed by odd parity
    task automatic expect_byte(input logic [7:0] b, input int nbits);
        logic par;
        int   j;
        par = 1'b1;
        for (j = 0; j < nbits; j++) begin
            exp_bits.push_back(b[j]);
            par = par ^ b[j];
        end
        exp_bits.push_back(par);
    endtask

    task automatic load_cases(output bit ok);
        int    fd;
        int    r;
        int    fb;
        int    cf;
        int    fdt;
        int    nb;
        int    v;
        int    i;
        int    nbits;
        string tok;
        string line;
        ok = 1'b0;
        fd = $fopen("tests/tx_cases.txt", "r");
        if (fd != 0) begin
            // reset and closing margin
            cycle_limit = 100;
            r = $fscanf(fd, "%s", tok);
            while (r == 1) begin
                if (tok.getc(0) == "#") begin
                    r = $fgets(line, fd);
                end else begin
                    r = $fscanf(fd, "%d %d %d %d", fb, cf, fdt, nb);
                    case_name.push_back(tok);
                    case_fb.push_back(fb);
                    case_crcf.push_back(cf);
                    case_fdt.push_back(fdt);
                    case_nb.push_back(nb);
                    case_base.push_back(case_bytes.size());
                    for (i = 0; i < nb; i++) begin
                        r = $fscanf(fd, "%h", v);
                        case_bytes.push_back(v[7:0]);
                    end
                    r = $fscanf(fd, "%h", v);
                    case_crc.push_back(v[15:0]);
                    // start bit, data with parity, crc bytes, idle end bit
                    nbits = 2 + ((fb == 0) ? 8 : fb) + 1 + (nb - 1) * 9;
                    nbits = nbits + ((cf != 0) ? 18 : 0);
                    // apb traffic around each frame
                    cycle_limit = cycle_limit + nbits * `BIT_TICKS + fdt + (nb + 12) * 8;
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            ok = case_name.size() > 0;
        end
    endtask

    task automatic run_case(input int k);
        int          fb;
        int          nb;
        int          fdt;
        int          base;
        int          i;
        int          lat;
        logic        crcf;
        logic [15:0] crc_exp;
        logic [31:0] rdata;
        logic        err;

        test_name   = case_name[k];
        fb          = case_fb[k];
        nb          = case_nb[k];
        fdt         = case_fdt[k];
        base        = case_base[k];
        crcf        = case_crcf[k] != 0;
        crc_exp     = case_crc[k];
        case_errors = 0;

        // start bit, data bytes, then crc low byte first
        exp_bits.delete();
        exp_bits.push_back(1'b1);
        for (i = 0; i < nb; i++) begin
            expect_byte(case_bytes[base + i], (i == 0 && fb != 0) ? fb : 8);
        end
        if (crcf) begin
            expect_byte(crc_exp[7:0], 8);
            expect_byte(crc_exp[15:8], 8);
        end

        idle_gap();
        bus_access(1'b1, `REG_FDT, 32'(fdt), rdata, err);
        check_value("fdt write pslverr", 0, 32'(err));
        for (i = 0; i < nb; i++) begin
            idle_gap();
            bus_access(1'b1, `REG_TXDATA, 32'(case_bytes[base + i]), rdata, err);
            check_value("txdata write pslverr", 0, 32'(err));
        end
        idle_gap();
        bus_access(1'b0, `REG_STATUS, 0, rdata, err);
        check_value("fifo level", 32'(nb), 32'(rdata[12:8]));
        check_value("busy before start", 0, 32'(rdata[0]));

        // one byte too many is refused
        if (nb == `TX_FIFO_DEPTH) begin
            bus_access(1'b1, `REG_TXDATA, 32'h0000_00ff, rdata, err);
            check_value("full fifo pslverr", 1, 32'(err));
            bus_access(1'b0, `REG_STATUS, 0, rdata, err);
            check_value("fifo level when full", 32'(nb), 32'(rdata[12:8]));
        end

        // unmapped offsets
        bus_access(1'b1, 8'h14, 32'h1234_5678, rdata, err);
        check_value("unmapped write pslverr", 1, 32'(err));
        bus_access(1'b0, 8'h20, 0, rdata, err);
        check_value("unmapped read pslverr", 1, 32'(err));

        idle_gap();
        bus_access(1'b1, `REG_CTRL, {27'd0, crcf, 3'(fb), 1'b1}, rdata, err);
        check_value("start pslverr", 0, 32'(err));

        // cycles from the start write to the first modulated cycle
        lat = 0;
        @(negedge clk);
        while (!tx_active) begin
            lat++;
            @(negedge clk);
        end
        if (lat < fdt + 1 || lat >= fdt + 1 + setup_cycles) begin
            $display("%s: tx_active rose %0d cycles after the start write with fdt %0d",
                     test_name, lat, fdt);
            errors++;
            case_errors++;
        end

        bus_access(1'b0, `REG_STATUS, 0, rdata, err);
        check_value("busy during frame", 1, 32'(rdata[0]));
        check_value("done during frame", 0, 32'(rdata[1]));
        // a restart is refused and the frame must carry on untouched
        bus_access(1'b1, `REG_CTRL, {27'd0, crcf, 3'(fb), 1'b1}, rdata, err);
        check_value("start while busy pslverr", 1, 32'(err));

        @(negedge clk);
        while (!tx_done) @(negedge clk);
        if (!decode_done) begin
            $display("%s: tx_done came before the end of the modulated frame", test_name);
            errors++;
            case_errors++;
        end else if (bad_symbol) begin
            $display("%s: a bit period was modulated in both halves", test_name);
            errors++;
            case_errors++;
        end
        check_value("bit count", 32'(exp_bits.size()), 32'(rx_bits.size()));
        if (exp_bits.size() == rx_bits.size()) begin
            for (i = 0; i < exp_bits.size(); i++) begin
                check_value($sformatf("bit %0d", i), 32'(exp_bits[i]), 32'(rx_bits[i]));
            end
        end

        idle_gap();
        bus_access(1'b0, `REG_STATUS, 0, rdata, err);
        check_value("busy after frame", 0, 32'(rdata[0]));
        check_value("done after frame", 1, 32'(rdata[1]));
        check_value("fifo level after frame", 0, 32'(rdata[12:8]));
        bus_access(1'b0, `REG_CRC, 0, rdata, err);
        check_value("crc register", 32'(crc_exp), 32'(rdata[15:0]));

        $display("%s: %0d bits decoded, %s", test_name, rx_bits.size(),
                 (case_errors == 0) ? "ok" : "failed");
    endtask

    initial begin
        bit ok;
        int k;
        clk         = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        decode_done = 1'b0;
        bad_symbol  = 1'b0;
        void'($urandom(32'hd56bef81));
        load_cases(ok);
        if (!ok) begin
            $display("could not read any test case from tests/tx_cases.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            rst_n <= 1'b1;
            for (k = 0; k < case_name.size(); k++) begin
                run_case(k);
            end
            $display("%0d tests run, %0d errors", case_name.size(), errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// ==== tests/tx_cases.txt ====
# name first_bits append_crc fdt byte_count bytes expected_crc
# fdt and counts in decimal, bytes and crc in hex, first_bits 0 means 8
hlta        0 1 20 2 50 00 cd57
rats        0 1 7  2 e0 50 a5bc
read_blk0   0 1 0  2 30 00 a802
read_pg4    0 1 33 2 30 04 ee26
auth_a      0 1 12 2 60 00 7bf5
hlta_crc    0 1 9  4 50 00 57 cd 0000
reqa        7 0 5  1 26 15ca
wupa        7 0 3  1 52 2069
fifo_full   0 1 14 16 50 00 57 cd 00 00 00 00 00 00 00 00 00 00 00 00 0000

// ==== iso14443a_tx.f ====
+incdir+common
common/iso14443a_pkg.sv
verilog/apb_tx_regs.sv
verilog/fdt_timer.sv
verilog/tx_byte_serializer.sv
frame_encode/frame_encode.sv
verilog/manchester_encoder.sv
verilog/iso14443a_tx.sv
tests/tb_iso14443a_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_iso14443a_tx \
    -f iso14443a_tx.f -o tb_sim

output="$(./obj_dir/tb_sim)"
echo "$output"

if echo "$output" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1
